// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_frame_engine
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) frame_engine_input.txt
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
stream_pkg.sv
skidbuffer.sv
frame_ctrl.sv
payload_alu.sv
frame_checksum.sv
frame_engine.sv
frame_engine_chk.sv
tb_frame_engine.sv

// ==== frame_checksum.sv ====
`timescale 1ns/1ns

module frame_checksum (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          clear,
  input  logic                          step,
  input  logic [stream_pkg::word_w-1:0] word,
  output logic [stream_pkg::word_w-1:0] sum
);
  import stream_pkg::*;

  logic [word_w-1:0] acc_q;

  assign sum = acc_q;

  // clear and step never fire together, header and payload are distinct words.
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (clear) begin
      acc_q <= '0;
    end else if (step) begin
      acc_q <= acc_q ^ word;
    end
  end

endmodule

// ==== frame_ctrl.sv ====
`timescale 1ns/1ns

module frame_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          s_valid,
  output logic                          s_ready,
  input  logic [stream_pkg::word_w-1:0] s_data,
  output logic                          o_valid,
  input  logic                          o_ready,
  output logic [stream_pkg::word_w-1:0] o_data,
  output logic                          load_key,
  output logic                          step,
  output logic                          clear,
  input  logic [stream_pkg::word_w-1:0] alu_data,
  input  logic [stream_pkg::word_w-1:0] sum
);
  import stream_pkg::*;

  logic [1:0]  state;
  logic [7:0]  remaining;
  logic        xfer;
  frame_word_t s_word;

  assign s_word = s_data;
  assign xfer   = s_valid && o_ready; // only meaningful outside the trailer.

  always_comb begin
    o_valid  = s_valid;
    o_data   = s_data;
    s_ready  = o_ready;
    load_key = 1'b0;
    step     = 1'b0;
    clear    = 1'b0;
    case (state)
      st_header: begin
        load_key = xfer;
        clear    = xfer;
      end
      st_payload: begin
        o_data = alu_data;
        step   = xfer;
      end
      st_trailer: begin
        // emit the checksum; input is held off for this cycle.
        o_valid = 1'b1;
        o_data  = sum;
        s_ready = 1'b0;
      end
      default: begin
        o_valid = 1'b0;
        s_ready = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_header;
      remaining <= 8'd0;
    end else begin
      case (state)
        st_header: begin
          if (xfer) begin
            remaining <= s_word.hdr.length;
            if (s_word.hdr.length == 8'd0) state <= st_trailer;
            else state <= st_payload;
          end
        end
        st_payload: begin
          if (xfer) begin
            remaining <= remaining - 8'd1;
            if (remaining == 8'd1) state <= st_trailer; // last payload word.
          end
        end
        st_trailer: begin
          if (o_ready) state <= st_header;
        end
        default: begin
          state <= st_header;
        end
      endcase
    end
  end

endmodule

// ==== frame_engine.sv ====
`timescale 1ns/1ns

module frame_engine (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [stream_pkg::word_w-1:0] in_data,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [stream_pkg::word_w-1:0] out_data
);
  import stream_pkg::*;

  logic              s_valid;
  logic              s_ready;
  logic [word_w-1:0] s_data;
  logic              o_valid;
  logic              o_ready;
  logic [word_w-1:0] o_data;
  logic              load_key;
  logic              step;
  logic              clear;
  logic [word_w-1:0] alu_data;
  logic [word_w-1:0] sum;

  skidbuffer #(.WIDTH(word_w)) u_in_skid (
    .clk          (clk),
    .reset        (reset),
    .input_ready  (in_ready),
    .input_valid  (in_valid),
    .input_data   (in_data),
    .output_ready (s_ready),
    .output_valid (s_valid),
    .output_data  (s_data)
  );

  frame_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_data   (s_data),
    .o_valid  (o_valid),
    .o_ready  (o_ready),
    .o_data   (o_data),
    .load_key (load_key),
    .step     (step),
    .clear    (clear),
    .alu_data (alu_data),
    .sum      (sum)
  );

  payload_alu u_alu (
    .clk      (clk),
    .reset    (reset),
    .load_key (load_key),
    .hdr      (s_data),
    .data     (s_data),
    .result   (alu_data)
  );

  frame_checksum u_sum (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .step  (step),
    .word  (alu_data), // checksum covers transformed words.
    .sum   (sum)
  );

  skidbuffer #(.WIDTH(word_w)) u_out_skid (
    .clk          (clk),
    .reset        (reset),
    .input_ready  (o_ready),
    .input_valid  (o_valid),
    .input_data   (o_data),
    .output_ready (out_ready),
    .output_valid (out_valid),
    .output_data  (out_data)
  );

endmodule

// ==== frame_engine_chk.sv ====
`timescale 1ns/1ns

module frame_engine_chk (
  input logic                          clk,
  input logic                          reset,
  input logic                          in_valid,
  input logic                          in_ready,
  input logic [stream_pkg::word_w-1:0] in_data,
  input logic                          out_valid,
  input logic                          out_ready,
  input logic [stream_pkg::word_w-1:0] out_data
);

  int fail_count = 0;

  // a stalled input word stays on the bus.
  in_hold: assert property (
    @(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data)
  ) else begin
    $error("in_valid or in_data changed while in_ready was low");
    fail_count = fail_count + 1;
  end

  out_hold: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else begin
    $error("out_valid or out_data changed while out_ready was low");
    fail_count = fail_count + 1;
  end

  out_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high one cycle after reset");
      fail_count = fail_count + 1;
    end

  in_open: assert property (@(posedge clk) reset |=> in_ready)
    else begin
      $error("in_ready low one cycle after reset");
      fail_count = fail_count + 1;
    end

endmodule

bind frame_engine frame_engine_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_data   (in_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

// ==== frame_engine_input.txt ====
// per test: test number, stall mode (0 none, 1 random), input count, input words,
// then expected count and expected output words; all hex, ffffffff ends the list.
// pass, length 2
00000001 00000000
00000003 00021234 11112222 33334444
00000004 00021234 11112222 33334444 22226666
// xor with key 00ff
00000002 00000000
00000004 010300ff 12345678 a5a5a5a5 000000ff
00000005 010300ff 12345687 a5a5a55a 00000000 b791f3dd
// add with key 8001, first word wraps
00000003 00000000
00000003 02028001 ffff8000 00010000
00000004 02028001 00000001 00018001 00018000
// swap halves
00000004 00000000
00000003 0302beef 12345678 dead0001
00000004 0302beef 56781234 0001dead 5679cc99
// unknown opcode 7f acts as pass
00000005 00000000
00000002 7f010f0f cafef00d
00000003 7f010f0f cafef00d cafef00d
// length 0
00000006 00000000
00000001 0100ffff
00000002 0100ffff 00000000
// back to back frames: add, empty pass, xor
00000007 00000000
00000006 02010010 000000f0 00000000 0102ffff 0000ffff ffff0000
00000009 02010010 00000100 00000100 00000000 00000000
         0102ffff 00000000 ffffffff ffffffff
// random stalls: swap, add, xor, empty
00000008 00000001
0000000b 03030000 00010002 00030004 00050006 0202ffff ffffffff 00000001
         01025a5a 5a5a5a5a 0000a5a5 00000000
0000000f 03030000 00020001 00040003 00060005 00000007 0202ffff 0000fffe
         00010000 0001fffe 01025a5a 5a5a0000 0000ffff 5a5affff 00000000
         00000000
// random stalls: pass of 4, unknown opcode 04
00000009 00000001
00000007 00040000 01020304 10203040 11111111 80000000 04011234 87654321
00000009 00040000 01020304 10203040 11111111 80000000 80332255 04011234
         87654321 87654321
// end of list
ffffffff

// ==== payload_alu.sv ====
`timescale 1ns/1ns

module payload_alu (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_key,
  input  logic [stream_pkg::word_w-1:0] hdr,
  input  logic [stream_pkg::word_w-1:0] data,
  output logic [stream_pkg::word_w-1:0] result
);
  import stream_pkg::*;

  frame_word_t       hdr_w;
  frame_word_t       data_w;
  logic [7:0]        op_q;
  logic [15:0]       key_q;
  logic [word_w-1:0] key_ext;

  assign hdr_w   = hdr;
  assign data_w  = data;
  assign key_ext = {{(word_w-16){1'b0}}, key_q}; // zero extended.

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q  <= op_pass;
      key_q <= 16'd0;
    end else if (load_key) begin
      op_q  <= hdr_w.hdr.opcode;
      key_q <= hdr_w.hdr.key;
    end
  end

  always_comb begin
    case (op_q)
      op_xor:  result = data_w.data ^ key_ext;
      op_add:  result = data_w.data + key_ext; // wraps mod 2^32.
      op_swap: result = {data_w.data[15:0], data_w.data[31:16]};
      default: result = data_w.data; // pass and unknown opcodes.
    endcase
  end

endmodule

// ==== skidbuffer.sv ====
`timescale 1ns/1ns

module skidbuffer #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  output logic             input_ready,
  input  logic             input_valid,
  input  logic [WIDTH-1:0] input_data,
  input  logic             output_ready,
  output logic             output_valid,
  output logic [WIDTH-1:0] output_data
);
  import stream_pkg::*;

  logic [1:0]       state;
  logic [WIDTH-1:0] out_q;
  logic [WIDTH-1:0] spare_q;
  logic             insert;
  logic             remove;

  assign insert      = input_valid && input_ready;
  assign remove      = output_valid && output_ready;
  assign output_data = out_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= sk_empty;
      input_ready  <= 1'b1;
      output_valid <= 1'b0;
    end else begin
      case (state)
        sk_empty: begin
          if (insert) begin
            state        <= sk_busy;
            output_valid <= 1'b1;
          end
        end
        sk_busy: begin
          if (insert && !remove) begin
            state       <= sk_full; // output stalled, word parks in spare.
            input_ready <= 1'b0;
          end else if (!insert && remove) begin
            state        <= sk_empty;
            output_valid <= 1'b0;
          end
        end
        sk_full: begin
          if (remove) begin
            state       <= sk_busy;
            input_ready <= 1'b1;
          end
        end
        default: begin
          state <= sk_empty;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      sk_empty: begin
        if (insert) out_q <= input_data;
      end
      sk_busy: begin
        if (insert && remove) out_q <= input_data;
        else if (insert) spare_q <= input_data;
      end
      sk_full: begin
        if (remove) out_q <= spare_q; // spare drains to the output.
      end
      default: ;
    endcase
  end

endmodule

// ==== stream_pkg.sv ====
package stream_pkg;

  localparam int word_w = 32;

  // opcodes carried in the header word.
  localparam logic [7:0] op_pass = 8'd0;
  localparam logic [7:0] op_xor  = 8'd1;
  localparam logic [7:0] op_add  = 8'd2;
  localparam logic [7:0] op_swap = 8'd3;

  // skid buffer occupancy.
  localparam logic [1:0] sk_empty = 2'd0;
  localparam logic [1:0] sk_busy  = 2'd1;
  localparam logic [1:0] sk_full  = 2'd2;

  // frame controller states.
  localparam logic [1:0] st_header  = 2'd0;
  localparam logic [1:0] st_payload = 2'd1;
  localparam logic [1:0] st_trailer = 2'd2;

  // one stream word, seen either as a frame header or as raw payload.
  typedef union packed {
    struct packed {
      logic [7:0]  opcode;
      logic [7:0]  length;
      logic [15:0] key;
    } hdr;
    logic [word_w-1:0] data;
  } frame_word_t;

endpackage

// ==== tb_frame_engine.sv ====
`timescale 1ns/1ns

module tb_frame_engine;
  import stream_pkg::*;

  localparam int          mem_words = 256;
  localparam logic [31:0] end_mark  = 32'hffff_ffff;

  logic              clk = 1'b0;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  logic [word_w-1:0] in_data;
  logic              out_valid;
  logic              out_ready;
  logic [word_w-1:0] out_data;

  logic [31:0] stim [0:mem_words-1];
  logic [15:0] lfsr;
  logic        stall_mode = 1'b0;
  logic        in_fire = 1'b0;
  int          cycle = 0;
  int          first_in = -1;
  int          exp_base = 0;
  int          exp_cnt = 0;
  int          out_start = 0;
  int          out_total = 0;
  int          err_total = 0;
  int          cur_test = 0;
  int          limit_ns = 0;

  always #4 clk = ~clk;

  frame_engine u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  function automatic logic [31:0] word_at(input int a);
    return stim[a[7:0]];
  endfunction

  // taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  always @(posedge clk) begin : monitor
    int          idx;
    logic [31:0] want;
    in_fire = in_valid && in_ready;
    if (!reset && out_valid && out_ready) begin
      idx = out_total - out_start;
      assert (idx < exp_cnt) else begin
        $display("test %0d: unexpected extra output word %08h", cur_test, out_data);
        err_total = err_total + 1;
      end
      if (idx < exp_cnt) begin
        want = word_at(exp_base + idx);
        assert (out_data == want) else begin
          $display("** Error @%0t: test %0d word %0d expected %08h got %08h",
                   $time, cur_test, idx, want, out_data);
          err_total = err_total + 1;
        end
        // without stalls the output runs one word per cycle behind a 2 cycle latency.
        if (!stall_mode) begin
          assert (cycle == first_in + 2 + idx) else begin
            $display("** Error @%0t: test %0d word %0d at cycle %0d, expected cycle %0d",
                     $time, cur_test, idx, cycle, first_in + 2 + idx);
            err_total = err_total + 1;
          end
        end
      end
      out_total = out_total + 1;
    end
    cycle = cycle + 1;
  end

  task automatic run_test(input int in_base, input int n_in);
    int k;
    k = 0;
    first_in = -1;
    while (k < n_in || out_total - out_start < exp_cnt) begin
      @(negedge clk);
      if (in_valid && in_fire) begin
        if (k == 0) first_in = cycle - 1;
        k = k + 1;
      end
      if (k >= n_in) begin
        in_valid = 1'b0;
      end else if (!in_valid || in_fire) begin
        in_valid = stall_mode ? take_bit() : 1'b1; // a held word is never withdrawn.
        in_data  = word_at(in_base + k);
      end
      out_ready = stall_mode ? take_bit() : 1'b1;
    end
    in_valid = 1'b0;
  endtask

  initial begin : main
    int          p;
    int          n_in;
    int          n_exp;
    int          n_tests;
    int          total_words;
    int          passed;
    int          failed;
    int          err_start;
    logic        rst_ok;
    frame_word_t hdr;

    reset     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    lfsr      = 16'd36192;
    passed    = 0;
    failed    = 0;
    $readmemh("frame_engine_input.txt", stim);

    p           = 0;
    n_tests     = 0;
    total_words = 0;
    while (p < mem_words - 4 && word_at(p) != end_mark) begin
      n_in        = word_at(p + 2);
      n_exp       = word_at(p + 3 + n_in);
      total_words = total_words + n_in + n_exp;
      n_tests     = n_tests + 1;
      p           = p + 4 + n_in + n_exp;
    end
    limit_ns = 20 * total_words * 8 + 2000;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset  = 1'b0;
    rst_ok = 1'b1;
    assert (!out_valid && in_ready) else begin
      $display("** Error @%0t: after reset out_valid %0b in_ready %0b, expected 0 and 1",
               $time, out_valid, in_ready);
      rst_ok = 1'b0;
    end
    if (rst_ok) passed = passed + 1;
    else failed = failed + 1;
    $display("test 0 (reset state): %s", rst_ok ? "pass" : "fail");
    if (n_tests == 0) begin
      $display("no test records found in frame_engine_input.txt");
      failed = failed + 1;
    end

    p = 0;
    while (p < mem_words - 4 && word_at(p) != end_mark) begin
      n_in       = word_at(p + 2);
      hdr        = word_at(p + 3);
      cur_test   = word_at(p);
      stall_mode = (word_at(p + 1) != 32'd0);
      exp_cnt    = word_at(p + 3 + n_in);
      exp_base   = p + 4 + n_in;
      out_start  = out_total;
      err_start  = err_total;
      run_test(p + 3, n_in);
      out_ready = 1'b1;
      repeat (2) @(negedge clk); // idle gap where a stray word shows up as extra.
      if (err_total == err_start) passed = passed + 1;
      else failed = failed + 1;
      $display("test %0d (op %02h, len %0d, %s): %0d words, %s", cur_test,
               hdr.hdr.opcode, hdr.hdr.length, stall_mode ? "stalls" : "no stalls",
               exp_cnt, err_total == err_start ? "pass" : "fail");
      p = exp_base + exp_cnt;
    end

    if (u_dut.u_chk.fail_count != 0) begin
      $display("handshake checker saw %0d assertion failures", u_dut.u_chk.fail_count);
      failed = failed + 1;
    end
    $display("tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule
